//--- all.f
+incdir+logic
logic/hispi_pkg.sv
logic/pixel_stream_if.sv
logic/hispi_sync_decoder.sv
logic/pixel_word_fifo.sv
logic/pixel_serializer.sv
logic/hispi_rx_top.sv
verification/hispi_rx_tb.sv

//--- verification/hispi_rx_tb.sv
//--------------------------------------------------------------------
// hispi receiver testbench
// frame generator, reference pixel queue and port level checks
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

module hispi_rx_tb import hispi_pkg::*; ();

	localparam int		PW = `HISPI_PIX_WIDTH;
	localparam logic [31:0]	RAND_SEED = 32'hd22f7f00;
	localparam pix_word_t	IDLE_WORD = {`HISPI_LANES{12'hfff}};	// never part of a sync

	logic		clk;
	logic		i_reset;
	logic		i_clk_en;
	logic		i_align_done;
	pix_word_t	i_data;
	logic		o_locked;
	logic		o_pix_valid;
	logic [PW-1:0]	o_pix;
	logic		o_lval;
	logic		o_fval;
	logic		o_overflow;

	logic [PW-1:0]	exp_q[$];	// reference pixels, lane 0 first
	int		line_len_q[$];	// pixels per open line
	int		frame_len_q[$];	// pixels per open frame
	logic [PW-1:0]	exp_pix;
	int		exp_len;
	int		line_pix;
	int		frame_pix;
	logic		lval_prev;
	logic		fval_prev;
	logic		pix_valid_prev;	// pixel shown in the last clock
	logic		check_en;	// pixel + framing checks on
	logic		lock_forbidden;
	logic		ovf_allowed;
	logic		ovf_seen;
	int		errors;
	int		test_start;
	int		tests_run;
	int		tests_passed;
	int		words_sent;
	int		cycles;
	int		waited;

	hispi_rx_top uut (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_clk_en     (i_clk_en),
		.i_align_done (i_align_done),
		.i_data       (i_data),
		.o_locked     (o_locked),
		.o_pix_valid  (o_pix_valid),
		.o_pix        (o_pix),
		.o_lval       (o_lval),
		.o_fval       (o_fval),
		.o_overflow   (o_overflow)
	);

	always #10 clk = ~clk;	// 20 ns period

	//----------------------------------------------------------------------
	// helpers
	//----------------------------------------------------------------------
	task automatic fail_value(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		errors++;
		$display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		assert (actual === expected) else fail_value(name, expected, actual);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;	// inputs move just after the edge
		end
	endtask

	function automatic int pace_gap(input logic fast);
		return fast ? 0 : 3 + int'($urandom % 3);	// at least three idle clocks
	endfunction

	function automatic pix_word_t random_payload();
		pix_word_t w;
		w[31:0]  = $urandom;
		w[47:32] = 16'($urandom);
		if (w[PW-1:0] == '0)
			w[PW-1:0] = 12'h001;	// lane 0 of payload never zero
		return w;
	endfunction

	task automatic send_word(input pix_word_t w, input int gap);
		i_data   = w;
		i_clk_en = 1'b1;
		words_sent++;
		idle(1);
		i_clk_en = 1'b0;
		idle(gap);
	endtask

	// zero, zero, code on every lane
	task automatic send_sync(input sync_code_e code, input logic fast);
		send_word('0, pace_gap(fast));
		send_word('0, pace_gap(fast));
		send_word({`HISPI_LANES{8'h00, code}}, pace_gap(fast));
	endtask

	task automatic send_line(input sync_code_e start_code, input sync_code_e end_code,
			input int n_words, input logic fast, input logic keep);
		pix_word_t w;
		int i;
		int l;
		if (keep)
			line_len_q.push_back(n_words * `HISPI_LANES);
		send_sync(start_code, fast);
		for (i = 0; i < n_words; i++) begin
			w = random_payload();
			if (keep) begin
				for (l = 0; l < `HISPI_LANES; l++)
					exp_q.push_back(w[l*PW +: PW]);
			end
			send_word(w, pace_gap(fast));
		end
		send_sync(end_code, fast);
		send_word(IDLE_WORD, pace_gap(fast));	// end code is found on this enable
	endtask

	task automatic send_frame(input int n_lines, input logic keep);
		int words[$];
		int total;
		int i;
		sync_code_e start_code;
		sync_code_e end_code;
		total = 0;
		for (i = 0; i < n_lines; i++) begin
			words.push_back(1 + int'($urandom % 6));
			total += words[i];
		end
		if (keep)
			frame_len_q.push_back(total * `HISPI_LANES);
		for (i = 0; i < n_lines; i++) begin
			start_code = (i == 0) ? SYNC_SOF : SYNC_SOL;
			end_code   = (i == n_lines - 1) ? SYNC_EOF : SYNC_EOL;
			send_line(start_code, end_code, words[i], 1'b0, keep);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() > 0 || line_len_q.size() > 0 || frame_len_q.size() > 0)
			idle(1);
		idle(2);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start) begin
			tests_passed++;
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_start);
		end
		test_start = errors;
	endtask

	//----------------------------------------------------------------------
	// output checks
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		if (!i_reset && check_en) begin
			if (lval_prev && !o_lval) begin	// line just closed
				assert (line_len_q.size() > 0) else begin
					errors++;
					$display("lval fell at %0t with no line outstanding", $time);
				end
				assert (pix_valid_prev) else begin
					errors++;
					$display("lval fell at %0t but not right after a pixel", $time);
				end
				if (line_len_q.size() > 0) begin
					exp_len = line_len_q.pop_front();
					assert (line_pix == exp_len) else fail_value("o_lval pixels", exp_len, line_pix);
				end
				line_pix = 0;
			end
			if (fval_prev && !o_fval) begin	// frame just closed
				assert (frame_len_q.size() > 0) else begin
					errors++;
					$display("fval fell at %0t with no frame outstanding", $time);
				end
				assert (pix_valid_prev) else begin
					errors++;
					$display("fval fell at %0t but not right after a pixel", $time);
				end
				if (frame_len_q.size() > 0) begin
					exp_len = frame_len_q.pop_front();
					assert (frame_pix == exp_len) else fail_value("o_fval pixels", exp_len, frame_pix);
				end
				frame_pix = 0;
			end
			if (o_pix_valid) begin
				assert (exp_q.size() > 0) else begin
					errors++;
					$display("pixel %0h at %0t while none was expected", o_pix, $time);
				end
				if (exp_q.size() > 0) begin
					exp_pix = exp_q.pop_front();
					assert (o_pix == exp_pix) else fail_value("o_pix", exp_pix, o_pix);
				end
				assert (o_lval) else fail_value("o_lval", 1'b1, o_lval);
				assert (o_fval) else fail_value("o_fval", 1'b1, o_fval);
				if (o_lval)
					line_pix++;
				frame_pix++;
			end
			assert (o_fval || !o_lval) else begin
				errors++;
				$display("lval high outside fval at %0t", $time);
			end
		end
		lval_prev = o_lval;
		fval_prev = o_fval;
		pix_valid_prev = o_pix_valid;
	end

	// lock and sticky overflow
	always @(posedge clk) begin
		if (i_reset) begin
			ovf_seen = 1'b0;
		end else begin
			if (lock_forbidden)
				assert (!o_locked) else fail_value("o_locked", 1'b0, o_locked);
			if (!ovf_allowed)
				assert (!o_overflow) else fail_value("o_overflow", 1'b0, o_overflow);
			if (ovf_seen)
				assert (o_overflow) else begin
					errors++;
					$display("overflow flag cleared without reset at %0t", $time);
				end
			if (o_overflow)
				ovf_seen = 1'b1;
		end
	end

	// watchdog, limit grows with the words generated
	always @(posedge clk) begin
		cycles++;
		if (cycles > 2 * words_sent * 4 + 200) begin
			$display("timeout after %0d cycles with %0d words sent", cycles, words_sent);
			$display("Something failed");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// test sequence
	//----------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		i_reset = 1'b1;
		i_clk_en = 1'b0;
		i_align_done = 1'b0;
		i_data = '0;
		check_en = 1'b1;
		lock_forbidden = 1'b1;
		ovf_allowed = 1'b0;
		ovf_seen = 1'b0;
		errors = 0;
		test_start = 0;
		tests_run = 0;
		tests_passed = 0;
		words_sent = 0;
		cycles = 0;
		line_pix = 0;
		frame_pix = 0;
		lval_prev = 1'b0;
		fval_prev = 1'b0;
		pix_valid_prev = 1'b0;
		void'($urandom(RAND_SEED));
		idle(4);
		i_reset = 1'b0;

		// no lock before alignment, none on line traffic alone
		send_frame(1, 1'b0);
		i_align_done = 1'b1;
		idle(4);	// two flop synchronizer
		send_line(SYNC_SOL, SYNC_EOL, 3, 1'b0, 1'b0);
		check_level("o_locked", o_locked, 1'b0);
		lock_forbidden = 1'b0;
		send_frame(2, 1'b1);
		check_level("o_locked", o_locked, 1'b1);
		wait_drain();
		end_test("lock");

		send_frame(3, 1'b1);
		send_frame(2, 1'b1);
		wait_drain();
		end_test("pixel order");

		send_frame(4, 1'b1);
		send_frame(1, 1'b1);	// single line, sof and eof share it
		wait_drain();
		check_level("o_lval", o_lval, 1'b0);
		check_level("o_fval", o_fval, 1'b0);
		end_test("framing");

		// drop alignment in the frame gap
		i_align_done = 1'b0;
		while (o_locked)
			idle(1);
		lock_forbidden = 1'b1;
		send_line(SYNC_SOL, SYNC_EOL, 2, 1'b0, 1'b0);
		i_align_done = 1'b1;
		idle(4);
		send_line(SYNC_SOL, SYNC_EOL, 3, 1'b0, 1'b0);
		check_level("o_locked", o_locked, 1'b0);
		lock_forbidden = 1'b0;
		send_frame(2, 1'b1);
		check_level("o_locked", o_locked, 1'b1);
		wait_drain();
		end_test("alignment loss");

		// unpaced line, one enable per clock
		check_level("o_overflow", o_overflow, 1'b0);
		check_en = 1'b0;
		ovf_allowed = 1'b1;
		send_line(SYNC_SOF, SYNC_EOF, 40, 1'b1, 1'b0);
		waited = 0;
		while (!o_overflow && waited < 50) begin
			idle(1);
			waited++;
		end
		assert (o_overflow) else begin
			errors++;
			$display("o_overflow never rose during the unpaced line");
		end
		idle(20);	// sticky check runs meanwhile
		check_level("o_overflow", o_overflow, 1'b1);
		i_reset = 1'b1;
		idle(4);
		i_reset = 1'b0;
		idle(1);
		check_level("o_overflow", o_overflow, 1'b0);
		check_level("o_locked", o_locked, 1'b0);
		end_test("overflow");

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_passed, tests_run - tests_passed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- logic/hispi_rx_top.sv
//--------------------------------------------------------------------
// hispi receiver top
// sync decoder -> word FIFO -> pixel serializer
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

module hispi_rx_top import hispi_pkg::*; (
	input	logic				clk,
	input	logic				i_reset,
	input	logic				i_clk_en,	// deserializer word strobe
	input	logic				i_align_done,	// bit alignment level
	input	pix_word_t			i_data,	// lane 3..0, lane 0 low
	output	logic				o_locked,
	output	logic				o_pix_valid,
	output	logic [`HISPI_PIX_WIDTH-1:0]	o_pix,
	output	logic				o_lval,
	output	logic				o_fval,
	output	logic				o_overflow
);

	pixel_stream_if push_bus ();	// decoder to FIFO
	pixel_stream_if head_bus ();	// FIFO to serializer

	logic pop;

	// sync search and payload marking
	hispi_sync_decoder u_decoder (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_clk_en     (i_clk_en),
		.i_align_done (i_align_done),
		.i_word       (i_data),
		.o_locked     (o_locked),
		.o_stream     (push_bus.src)
	);

	// burst absorber
	pixel_word_fifo u_fifo (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_push     (push_bus.dst),
		.o_head     (head_bus.src),
		.i_pop      (pop),
		.o_overflow (o_overflow)
	);

	// one pixel per clock out
	pixel_serializer u_serializer (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_head      (head_bus.dst),
		.o_pop       (pop),
		.o_pix_valid (o_pix_valid),
		.o_pix       (o_pix),
		.o_lval      (o_lval),
		.o_fval      (o_fval)
	);

endmodule

//--- logic/pixel_serializer.sv
//--------------------------------------------------------------------
// pixel serializer
// one marked word out as four pixels, lane 0 first, with lval/fval
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

module pixel_serializer import hispi_pkg::*; (
	input	logic				clk,
	input	logic				i_reset,
	pixel_stream_if.dst			i_head,	// FIFO head, valid = not empty
	output	logic				o_pop,
	output	logic				o_pix_valid,
	output	logic [`HISPI_PIX_WIDTH-1:0]	o_pix,
	output	logic				o_lval,
	output	logic				o_fval
);

	localparam int PW = `HISPI_PIX_WIDTH;

	ser_state_e	state;
	logic [1:0]	lane_cnt;	// lane on o_pix
	logic		last_lane;
	logic		pop;

	pix_word_t	word_q;	// word being unloaded
	logic		eol_q;	// held end markers
	logic		eof_q;

	logic		lval_q;
	logic		fval_q;

	assign last_lane = (lane_cnt == 2'(`HISPI_LANES - 1));

	// take a word when idle or on the last pixel of the current one
	assign pop = i_head.valid &&
		((state == SER_IDLE) || ((state == SER_SHIFT) && last_lane));

	//----------------------------------------------------------------------
	// FSM and lane counter
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state    <= SER_IDLE;
			lane_cnt <= '0;
			lval_q   <= 1'b0;
			fval_q   <= 1'b0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (pop) begin
						state    <= SER_SHIFT;
						lane_cnt <= '0;
					end
				end
				SER_SHIFT: begin
					if (last_lane) begin
						lane_cnt <= '0;
						if (!pop)
							state <= SER_IDLE;	// nothing queued
					end else begin
						lane_cnt <= lane_cnt + 1'b1;
					end
				end
				default: state <= SER_IDLE;
			endcase

			// levels drop after the last pixel of a closing word
			if ((state == SER_SHIFT) && last_lane && eol_q)
				lval_q <= 1'b0;
			if ((state == SER_SHIFT) && last_lane && eof_q)
				fval_q <= 1'b0;

			// and rise with the first pixel of an opening word
			if (pop && (i_head.sof || i_head.sol))
				lval_q <= 1'b1;
			if (pop && i_head.sof)
				fval_q <= 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// word hold
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (pop) begin
			word_q <= i_head.word;
			eol_q  <= i_head.eol;
			eof_q  <= i_head.eof;
		end
	end

	assign o_pop       = pop;
	assign o_pix_valid = (state == SER_SHIFT);
	assign o_pix       = word_q[lane_cnt*PW +: PW];	// lane 0 low
	assign o_lval      = lval_q;
	assign o_fval      = fval_q;

endmodule

//--- logic/pixel_word_fifo.sv
//--------------------------------------------------------------------
// marked word FIFO
// first word fall through, drops on full and flags overflow
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

module pixel_word_fifo import hispi_pkg::*; (
	input	logic		clk,
	input	logic		i_reset,
	pixel_stream_if.dst	i_push,	// valid is a push strobe
	pixel_stream_if.src	o_head,	// valid is not-empty
	input	logic		i_pop,
	output	logic		o_overflow	// sticky until reset
);

	localparam int DEPTH = `HISPI_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	pix_word_t		mem_word [DEPTH];
	logic [3:0]		mem_mark [DEPTH];	// {eof, eol, sol, sof}

	logic [PTR_W-1:0]	wr_ptr;
	logic [PTR_W-1:0]	rd_ptr;
	logic [CNT_W-1:0]	count;
	logic			full;
	logic			empty;
	logic			push_ok;
	logic			pop_ok;
	logic			overflow;
	logic [3:0]		head_mark;

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign push_ok = i_push.valid && !full;	// full means drop
	assign pop_ok  = i_pop && !empty;

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem_word[wr_ptr] <= i_push.word;
			mem_mark[wr_ptr] <= {i_push.eof, i_push.eol, i_push.sol, i_push.sof};
		end
	end

	//----------------------------------------------------------------------
	// pointers, count, overflow
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none or both
			endcase

			if (i_push.valid && full)
				overflow <= 1'b1;	// word lost
		end
	end

	//----------------------------------------------------------------------
	// head always visible
	//----------------------------------------------------------------------
	assign head_mark = mem_mark[rd_ptr];

	assign o_head.valid = !empty;
	assign o_head.word  = mem_word[rd_ptr];
	assign o_head.sof   = head_mark[0];
	assign o_head.sol   = head_mark[1];
	assign o_head.eol   = head_mark[2];
	assign o_head.eof   = head_mark[3];

	assign o_overflow = overflow;

endmodule

//--- logic/hispi_sync_decoder.sv
//--------------------------------------------------------------------
// hispi sync decoder
// finds sof/sol/eol/eof on lane 0, strips sync words, tags payload
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

module hispi_sync_decoder import hispi_pkg::*; (
	input	logic		clk,
	input	logic		i_reset,
	input	logic		i_clk_en,	// word strobe from deserializer
	input	logic		i_align_done,	// async level, bit alignment done
	input	pix_word_t	i_word,
	output	logic		o_locked,
	pixel_stream_if.src	o_stream
);

	localparam int STAGES = 4;	// three sync words + last payload word
	localparam int PW = `HISPI_PIX_WIDTH;
	localparam int CW = `HISPI_CODE_WIDTH;

	logic			align_meta;	// sync flop 1
	logic			align_sync;	// sync flop 2

	dec_state_e		state;
	dec_state_e		state_nxt;

	logic [2:0][PW-1:0]	win;	// lane 0 window, [0] newest

	pix_word_t [STAGES-1:0]	stage_word;	// delay line, [STAGES-1] oldest
	logic [STAGES-1:0]	stage_tag;	// payload tag per stage
	logic [STAGES-1:0]	stage_sof;
	logic [STAGES-1:0]	stage_sol;

	sync_code_e		code;
	logic			sync_seen;
	logic			sof_det;
	logic			sol_det;
	logic			eol_det;
	logic			eof_det;
	logic			start_det;	// line opens on this enable
	logic			end_det;	// line closes on this enable
	logic			enter_tag;

	logic			push_valid;
	pix_word_t		push_word;
	logic			push_sof;
	logic			push_sol;
	logic			push_eol;
	logic			push_eof;

	//----------------------------------------------------------------------
	// sync detection on lane 0
	//----------------------------------------------------------------------
	assign code = sync_code_e'(win[0][CW-1:0]);

	// zero, zero, then code with the upper bits clear
	assign sync_seen = (win[2] == '0) && (win[1] == '0) && (win[0][PW-1:CW] == '0);

	assign sof_det = sync_seen && (code == SYNC_SOF);
	assign sol_det = sync_seen && (code == SYNC_SOL);
	assign eol_det = sync_seen && (code == SYNC_EOL);
	assign eof_det = sync_seen && (code == SYNC_EOF);

	// only sof opens a line before lock
	assign start_det = ((state == DEC_UNLOCKED) && sof_det) ||
		((state == DEC_FRAME_GAP) && (sof_det || sol_det));
	assign end_det = (state == DEC_LINE) && (eol_det || eof_det);

	// incoming word is payload when a line is open or opens now
	assign enter_tag = (state == DEC_LINE) || start_det;

	//----------------------------------------------------------------------
	// FSM next state
	//----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			DEC_UNLOCKED: begin
				if (sof_det)
					state_nxt = DEC_LINE;	// first sof locks
			end
			DEC_FRAME_GAP: begin
				if (sof_det || sol_det)
					state_nxt = DEC_LINE;
			end
			DEC_LINE: begin
				if (eol_det || eof_det)
					state_nxt = DEC_FRAME_GAP;
			end
			default: state_nxt = DEC_UNLOCKED;
		endcase
	end

	//----------------------------------------------------------------------
	// control: sync flops, window, tags, state
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			align_meta <= 1'b0;
			align_sync <= 1'b0;
			win        <= '0;
			state      <= DEC_UNLOCKED;
			stage_tag  <= '0;
			stage_sof  <= '0;
			stage_sol  <= '0;
			push_valid <= 1'b0;
		end else begin
			align_meta <= i_align_done;
			align_sync <= align_meta;
			push_valid <= 1'b0;	// one clock strobe

			// window keeps running so sof can be found while unlocked
			if (i_clk_en)
				win <= {win[1:0], i_word[PW-1:0]};

			if (!align_sync) begin
				// alignment lost, drop everything in flight
				state     <= DEC_UNLOCKED;
				stage_tag <= '0;
				stage_sof <= '0;
				stage_sol <= '0;
			end else if (i_clk_en) begin
				state      <= state_nxt;
				push_valid <= stage_tag[STAGES-1];	// oldest leaves now
				if (end_det)
					stage_tag <= '0;	// the three sync words are not payload
				else
					stage_tag <= {stage_tag[STAGES-2:0], enter_tag};
				stage_sof <= {stage_sof[STAGES-2:0], start_det && sof_det};
				stage_sol <= {stage_sol[STAGES-2:0], start_det && sol_det};
			end
		end
	end

	//----------------------------------------------------------------------
	// delay line and push word
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_clk_en) begin
			stage_word <= {stage_word[STAGES-2:0], i_word};
			push_word  <= stage_word[STAGES-1];
			push_sof   <= stage_sof[STAGES-1];
			push_sol   <= stage_sol[STAGES-1];
			push_eol   <= end_det;	// oldest stage is last of line
			push_eof   <= end_det && eof_det;
		end
	end

	assign o_stream.valid = push_valid;
	assign o_stream.word  = push_word;
	assign o_stream.sof   = push_sof;
	assign o_stream.sol   = push_sol;
	assign o_stream.eol   = push_eol;
	assign o_stream.eof   = push_eof;

	assign o_locked = (state != DEC_UNLOCKED);

endmodule

//--- logic/pixel_stream_if.sv
//--------------------------------------------------------------------
// marked pixel word link
// one four-lane word plus its frame and line boundary flags
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "hispi_defines.svh"

interface pixel_stream_if import hispi_pkg::*; ();

	logic		valid;	// push strobe or not-empty level
	pix_word_t	word;	// four lanes, lane 0 low
	logic		sof;	// first word of frame
	logic		sol;	// first word of line
	logic		eol;	// last word of line
	logic		eof;	// last word of frame

	// sending side
	modport src (
		output valid, word,
		output sof, sol, eol, eof
	);

	// receiving side
	modport dst (
		input valid, word,
		input sof, sol, eol, eof
	);

endinterface

//--- logic/hispi_pkg.sv
//--------------------------------------------------------------------
// hispi receive types
// sync codes, FSM states and the packed four-lane word
//--------------------------------------------------------------------
`include "hispi_defines.svh"

package hispi_pkg;

	//----------------------------------------------------------------------
	// sync codes
	//----------------------------------------------------------------------
	// code sits in the low bits of the third sync word, rest all zero
	typedef enum logic [`HISPI_CODE_WIDTH-1:0] {
		SYNC_SOL = 4'd1,	// start of line
		SYNC_SOF = 4'd3,	// start of frame
		SYNC_EOL = 4'd5,	// end of line
		SYNC_EOF = 4'd7	// end of frame
	} sync_code_e;

	//----------------------------------------------------------------------
	// FSM states
	//----------------------------------------------------------------------
	typedef enum logic [1:0] {
		DEC_UNLOCKED,	// waiting for align + first sof
		DEC_FRAME_GAP,	// locked, between lines
		DEC_LINE	// payload words being tagged
	} dec_state_e;

	typedef enum logic {
		SER_IDLE,	// nothing held
		SER_SHIFT	// unloading four lanes
	} ser_state_e;

	//----------------------------------------------------------------------
	// data word
	//----------------------------------------------------------------------
	// little endian lane order, lane 0 in the low bits
	typedef logic [`HISPI_LANES*`HISPI_PIX_WIDTH-1:0] pix_word_t;

endpackage

//--- logic/hispi_defines.svh
//--------------------------------------------------------------------
// hispi receive side global sizes
// lanes, pixel width, buffer depth and sync code field
//--------------------------------------------------------------------
`ifndef HISPI_DEFINES_SVH
`define HISPI_DEFINES_SVH

// four data lanes from the deserializer
`define HISPI_LANES       4
// bits per lane word
`define HISPI_PIX_WIDTH   12
// marked word entries in the rx buffer
`define HISPI_FIFO_DEPTH  16
// low bits of the third sync word holding the code
`define HISPI_CODE_WIDTH  4

`endif
